/* hdl/lsu_pkg.sv */
package lsu_pkg;

    localparam int addr_w       = 32;
    localparam int data_w       = 32;
    localparam int sb_depth     = 4;
    localparam int port_depth   = 2;
    localparam int read_latency = 2;
    localparam int mem_words    = 256;
    localparam int mem_idx_w    = $clog2(mem_words);

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    // one queued CPU request, waiting for its turn on the memory bus.
    typedef struct packed {
        logic              wr;
        size_t             size;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } sb_entry_t;

    // tag kept for each request in flight inside the memory port.
    typedef struct packed {
        logic       wr;
        logic [1:0] offset;
    } port_entry_t;

    // byte enables for an access of the given size at the given byte offset.
    function automatic logic [3:0] byte_lanes(size_t size, logic [1:0] offset);
        logic [3:0] lanes;
        case (size)
            size_byte: lanes = 4'b0001 << offset;
            size_half: lanes = offset[1] ? 4'b1100 : 4'b0011;
            default:   lanes = 4'b1111;
        endcase
        return lanes;
    endfunction

endpackage

/* hdl/entry_ring.sv */
`timescale 1ns/1ps

module entry_ring #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     resetn,

    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head_data,
    output logic     empty,
    output logic     full
);

    localparam int idx_w = $clog2(depth);

    payload_t         slots [depth];
    logic [depth-1:0] occ;
    logic [idx_w-1:0] head;
    logic [idx_w-1:0] tail;

    // head points at the oldest entry, tail at the next free slot.
    assign head_data = slots[head];
    assign empty     = ~occ[head];
    assign full      = occ[tail];

    always_ff @(posedge clk) begin
        if (resetn) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (push && tail == idx_w'(i)) begin
                    occ[i] <= 1'b1;
                end else if (pop && head == idx_w'(i)) begin
                    occ[i] <= 1'b0;
                end
            end
            if (push) begin
                tail <= idx_w'(tail + 1'b1);
            end
            if (pop) begin
                head <= idx_w'(head + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[tail] <= push_data;
        end
    end

endmodule

/* hdl/data_sram.sv */
`timescale 1ns/1ps

module data_sram import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 en,
    input  logic [3:0]           we,
    input  logic [mem_idx_w-1:0] index,
    input  logic [data_w-1:0]    wdata,
    output logic [data_w-1:0]    rdata
);

    logic [data_w-1:0] mem [mem_words];

    // simulation starts from an all-zero memory.
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // a read during a write returns the old word.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[index];
        end
    end

endmodule

/* hdl/sram_port.sv */
`timescale 1ns/1ps

module sram_port import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 mem_req,
    input  logic                 mem_wr,
    input  size_t                mem_size,
    input  logic [addr_w-1:0]    mem_addr,
    input  logic [data_w-1:0]    mem_wdata,
    output logic                 mem_addr_ok,
    output logic                 mem_data_ok,
    output logic [data_w-1:0]    mem_rdata,

    output logic                 ram_en,
    output logic [3:0]           ram_we,
    output logic [mem_idx_w-1:0] ram_index,
    output logic [data_w-1:0]    ram_wdata,
    input  logic [data_w-1:0]    ram_rdata
);

    logic                    accept;
    logic                    tag_full;
    port_entry_t             tag_in;
    port_entry_t             tag_head;
    logic [read_latency-1:0] pending;
    logic [data_w-1:0]       rdata_pipe [1:read_latency-1];

    assign mem_addr_ok = !tag_full;
    assign accept      = mem_req && mem_addr_ok;

    // every accepted request turns into exactly one SRAM access.
    assign ram_en    = accept;
    assign ram_we    = (accept && mem_wr) ? byte_lanes(mem_size, mem_addr[1:0]) : 4'b0000;
    assign ram_index = mem_addr[mem_idx_w+1:2];
    assign ram_wdata = mem_wdata;

    assign tag_in = '{wr: mem_wr, offset: mem_addr[1:0]};

    entry_ring #(
        .payload_t (port_entry_t),
        .depth     (port_depth)
    ) u_tags (
        .clk       (clk),
        .resetn    (resetn),
        .push      (accept),
        .push_data (tag_in),
        .pop       (mem_data_ok),
        .head_data (tag_head),
        .empty     (),
        .full      (tag_full)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            pending <= '0;
        end else begin
            pending <= {pending[read_latency-2:0], accept};
        end
    end

    // SRAM data shows up one cycle after the access, in step with pending[0].
    always_ff @(posedge clk) begin
        if (pending[0]) begin
            rdata_pipe[1] <= ram_rdata;
        end
        for (int i = 2; i < read_latency; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    assign mem_data_ok = pending[read_latency-1];

    // store completions carry no data.
    assign mem_rdata = tag_head.wr ? '0 : rdata_pipe[read_latency-1];

endmodule

/* hdl/store_buffer.sv */
`timescale 1ns/1ps

module store_buffer import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,

    input  logic              req,
    input  logic              wr,
    input  size_t             size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [data_w-1:0] rdata,

    output logic              mem_req,
    output logic              mem_wr,
    output size_t             mem_size,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok,
    input  logic [data_w-1:0] mem_rdata
);

    sb_entry_t push_entry;
    sb_entry_t head_entry;
    logic      sb_empty;
    logic      sb_full;
    logic      cpu_accept;
    logic      push;
    logic      pop;
    logic      issued;
    logic      load_pending;

    // a queued load blocks new requests so that completions stay in order.
    assign addr_ok    = sb_empty || (!sb_full && !load_pending);
    assign cpu_accept = req && addr_ok;
    assign push       = cpu_accept && !(sb_empty && mem_data_ok);
    assign pop        = mem_data_ok && !sb_empty;

    assign push_entry = '{wr: wr, size: size, addr: addr, wdata: wdata};

    entry_ring #(
        .payload_t (sb_entry_t),
        .depth     (sb_depth)
    ) u_ring (
        .clk       (clk),
        .resetn    (resetn),
        .push      (push),
        .push_data (push_entry),
        .pop       (pop),
        .head_data (head_entry),
        .empty     (sb_empty),
        .full      (sb_full)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            issued       <= 1'b0;
            load_pending <= 1'b0;
        end else begin
            // the head goes out once and then waits for its completion.
            if (mem_data_ok) begin
                issued <= 1'b0;
            end else if (mem_req && mem_addr_ok) begin
                issued <= 1'b1;
            end

            if (pop && !head_entry.wr) begin
                load_pending <= 1'b0;
            end else if (push && !wr) begin
                load_pending <= 1'b1;
            end
        end
    end

    assign rdata = mem_rdata;

    always_comb begin
        if (sb_empty) begin
            mem_req   = req;
            mem_wr    = wr;
            mem_size  = size;
            mem_addr  = addr;
            mem_wdata = wdata;
            data_ok   = (req && wr) || mem_data_ok;
        end else begin
            mem_req   = !issued;
            mem_wr    = head_entry.wr;
            mem_size  = head_entry.size;
            mem_addr  = head_entry.addr;
            mem_wdata = head_entry.wdata;
            // stores are acknowledged on entry, loads when their data is back.
            data_ok   = (cpu_accept && wr) || (mem_data_ok && !head_entry.wr);
        end
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic              clk,
    input  logic              resetn,

    input  logic              req,
    input  logic              wr,
    input  size_t             size,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output logic [data_w-1:0] rdata
);

    logic                 mem_req;
    logic                 mem_wr;
    size_t                mem_size;
    logic [addr_w-1:0]    mem_addr;
    logic [data_w-1:0]    mem_wdata;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [data_w-1:0]    mem_rdata;

    logic                 ram_en;
    logic [3:0]           ram_we;
    logic [mem_idx_w-1:0] ram_index;
    logic [data_w-1:0]    ram_wdata;
    logic [data_w-1:0]    ram_rdata;

    store_buffer u_store_buffer (
        .clk, .resetn,
        .req, .wr, .size, .addr, .wdata,
        .addr_ok, .data_ok, .rdata,
        .mem_req, .mem_wr, .mem_size, .mem_addr, .mem_wdata,
        .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

    sram_port u_sram_port (
        .clk, .resetn,
        .mem_req, .mem_wr, .mem_size, .mem_addr, .mem_wdata,
        .mem_addr_ok, .mem_data_ok, .mem_rdata,
        .ram_en, .ram_we, .ram_index, .ram_wdata, .ram_rdata
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .index (ram_index),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* tb/lsu_asserts.sv */
`timescale 1ns/1ps

module lsu_asserts import lsu_pkg::*; (
    input logic              clk,
    input logic              resetn,
    input logic              req,
    input logic              wr,
    input size_t             size,
    input logic [addr_w-1:0] addr,
    input logic [data_w-1:0] wdata,
    input logic              addr_ok,
    input logic              mem_data_ok,
    input logic              sb_empty,
    input logic              sb_full
);

    int fail_count = 0;

    // a memory completion always belongs to a queued entry or to the bypassed request.
    a_mem_done_owned: assert property (
        @(posedge clk) disable iff (resetn)
        mem_data_ok |-> (!sb_empty || req)
    ) else begin
        fail_count++;
        $error("mem_data_ok arrived with an empty queue and no bypassed request");
    end

    a_full_blocks: assert property (
        @(posedge clk) disable iff (resetn)
        (sb_full && !mem_data_ok) |-> !addr_ok
    ) else begin
        fail_count++;
        $error("addr_ok high while the store buffer is full");
    end

    // the CPU holds a waiting request unchanged until it is taken.
    a_req_stable: assert property (
        @(posedge clk) disable iff (resetn)
        (req && !addr_ok) |=> (req && $stable(wr) && $stable(size)
                               && $stable(addr) && $stable(wdata))
    ) else begin
        fail_count++;
        $error("CPU request changed before addr_ok");
    end

endmodule

bind store_buffer lsu_asserts u_asserts (
    .clk         (clk),
    .resetn      (resetn),
    .req         (req),
    .wr          (wr),
    .size        (size),
    .addr        (addr),
    .wdata       (wdata),
    .addr_ok     (addr_ok),
    .mem_data_ok (mem_data_ok),
    .sb_empty    (sb_empty),
    .sb_full     (sb_full)
);

/* tb/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    typedef struct {
        string       name;
        logic        wr;
        size_t       size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
    } step_t;

    localparam int n_steps = 14;
    localparam int wait_limit = 100;

    // merged word at 0x020 is 55 c4 b2 a1 from lanes 3 down to 0.
    step_t steps [n_steps] = '{
        '{"reset_load_low",   1'b0, size_word, 32'h000, 32'h00000000, 32'h00000000},
        '{"reset_load_high",  1'b0, size_word, 32'h3fc, 32'h00000000, 32'h00000000},
        '{"store_word",       1'b1, size_word, 32'h010, 32'h12345678, 32'h00000000},
        '{"load_word",        1'b0, size_word, 32'h010, 32'h00000000, 32'h12345678},
        '{"store_word_again", 1'b1, size_word, 32'h010, 32'hcafef00d, 32'h00000000},
        '{"store_other",      1'b1, size_word, 32'h014, 32'h0badbeef, 32'h00000000},
        '{"load_word_again",  1'b0, size_word, 32'h010, 32'h00000000, 32'hcafef00d},
        '{"store_byte0",      1'b1, size_byte, 32'h020, 32'heeeeeea1, 32'h00000000},
        '{"store_byte1",      1'b1, size_byte, 32'h021, 32'heeeeb2ee, 32'h00000000},
        '{"store_half_hi",    1'b1, size_half, 32'h022, 32'hc3c4eeee, 32'h00000000},
        '{"store_byte3",      1'b1, size_byte, 32'h023, 32'h55eeeeee, 32'h00000000},
        '{"load_merged",      1'b0, size_word, 32'h020, 32'h00000000, 32'h55c4b2a1},
        '{"load_half_hi",     1'b0, size_half, 32'h022, 32'h00000000, 32'h55c4b2a1},
        '{"load_other",       1'b0, size_word, 32'h014, 32'h00000000, 32'h0badbeef}
    };

    logic              clk;
    logic              resetn;
    logic              req;
    logic              wr;
    size_t             size;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              addr_ok;
    logic              data_ok;
    logic [data_w-1:0] rdata;

    logic [31:0] ref_mem [256];
    logic [31:0] cur_exp;
    logic        cur_fixed;
    string       cur_name;
    int          cycle;
    int          accepted;
    int          completed;
    int          stall_count;
    logic [31:0] rand_state;

    // one entry per request still waiting for its data_ok.
    logic        q_wr [$];
    logic [31:0] q_exp [$];
    int          q_cycle [$];
    logic        q_lat [$];
    string       q_name [$];

    lsu_top uut (
        .clk, .resetn,
        .req, .wr, .size, .addr, .wdata,
        .addr_ok, .data_ok, .rdata
    );

    always #2 clk = ~clk;

    task automatic fail(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [3:0] lanes_for(size_t s, logic [1:0] off);
        logic [3:0] m;
        for (int b = 0; b < 4; b++) begin
            if (s == size_word) begin
                m[b] = 1'b1;
            end else if (s == size_half) begin
                m[b] = ((b / 2) == int'(off[1]));
            end else begin
                m[b] = (b == int'(off));
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic write_ref(input logic [7:0] idx, input logic [3:0] lanes,
                             input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                ref_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic send(input logic w, input size_t s, input logic [31:0] a,
                        input logic [31:0] d, input logic [31:0] e,
                        input logic fixed, input string name);
        int waited;
        @(posedge clk);
        req       <= 1'b1;
        wr        <= w;
        size      <= s;
        addr      <= a;
        wdata     <= d;
        cur_exp   <= e;
        cur_fixed <= fixed;
        cur_name  <= name;
        waited = 0;
        @(negedge clk);
        while (!addr_ok) begin
            stall_count++;
            waited++;
            if (waited > wait_limit) begin
                fail($sformatf("no addr_ok for request %s", name));
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic idle();
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!uut.u_store_buffer.sb_empty) begin
            waited++;
            if (waited > wait_limit) begin
                fail("no data_ok for an outstanding request, or the buffer never drained");
            end else begin
                @(negedge clk);
            end
        end
        check("data_ok_count", accepted, completed);
    endtask

    // acceptances and completions are both seen at the falling edge.
    always @(negedge clk) begin : monitor
        logic [7:0]  idx;
        logic [31:0] pred;
        logic        f_wr;
        logic [31:0] f_exp;
        int          f_cycle;
        logic        f_lat;
        string       f_name;
        cycle = cycle + 1;
        if (!resetn) begin
            if (req && addr_ok) begin
                idx  = addr[9:2];
                pred = ref_mem[idx];
                if (wr) begin
                    write_ref(idx, lanes_for(size, addr[1:0]), wdata);
                end else if (cur_fixed) begin
                    check({cur_name, " table"}, cur_exp, pred);
                end
                q_wr.push_back(wr);
                q_exp.push_back(pred);
                q_cycle.push_back(cycle);
                q_lat.push_back(!wr && uut.u_store_buffer.sb_empty);
                q_name.push_back(cur_name);
                accepted++;
            end
            if (data_ok) begin
                if (q_wr.size() == 0) begin
                    fail("data_ok pulsed with no request outstanding");
                end else begin
                    f_wr    = q_wr.pop_front();
                    f_exp   = q_exp.pop_front();
                    f_cycle = q_cycle.pop_front();
                    f_lat   = q_lat.pop_front();
                    f_name  = q_name.pop_front();
                    completed++;
                    if (f_wr) begin
                        check({f_name, " ack cycle"}, f_cycle, cycle);
                    end else begin
                        check(f_name, f_exp, rdata);
                        if (f_lat) begin
                            check({f_name, " latency"}, 2, cycle - f_cycle);
                        end
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        size_t       s;
        clk         = 1'b0;
        resetn      = 1'b1;
        req         = 1'b0;
        wr          = 1'b0;
        size        = size_word;
        addr        = '0;
        wdata       = '0;
        cur_exp     = '0;
        cur_fixed   = 1'b0;
        cur_name    = "";
        cycle       = 0;
        accepted    = 0;
        completed   = 0;
        stall_count = 0;
        rand_state  = 32'h250d;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end

        repeat (16) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        check("reset_addr_ok", 1, addr_ok);
        check("reset_data_ok", 0, data_ok);

        for (int i = 0; i < n_steps; i++) begin
            send(steps[i].wr, steps[i].size, steps[i].addr, steps[i].wdata,
                 steps[i].exp_data, 1'b1, steps[i].name);
        end
        idle();
        wait_drain();

        // eight stores in a row overrun the four entries, so addr_ok must drop.
        stall_count = 0;
        for (int i = 0; i < 8; i++) begin
            send(1'b1, size_word, 32'h100 + 4 * i, 32'h5a000000 + i * 32'h00010203,
                 '0, 1'b0, $sformatf("burst_store_%0d", i));
        end
        idle();
        wait_drain();
        check("burst_addr_ok_drop", 1, stall_count > 0);
        for (int i = 0; i < 8; i++) begin
            send(1'b0, size_word, 32'h100 + 4 * i, '0, '0, 1'b0,
                 $sformatf("burst_load_%0d", i));
        end
        idle();
        wait_drain();

        for (int i = 0; i < 200; i++) begin
            rand_state = lcg_next(rand_state);
            r = rand_state;
            rand_state = lcg_next(rand_state);
            case (r[29:28])
                2'd0:    s = size_byte;
                2'd1:    s = size_half;
                default: s = size_word;
            endcase
            a = {26'd0, r[21:16]};
            if (s == size_half) begin
                a[0] = 1'b0;
            end else if (s == size_word) begin
                a[1:0] = 2'b00;
            end
            send(r[31], s, a, rand_state, '0, 1'b0, $sformatf("lcg_%0d", i));
        end
        idle();
        wait_drain();

        if (uut.u_store_buffer.u_asserts.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail("bound assertions on the bus handshakes reported failures");
        end
    end

endmodule

/* flist.f */
hdl/lsu_pkg.sv
hdl/entry_ring.sv
hdl/data_sram.sv
hdl/sram_port.sv
hdl/store_buffer.sv
hdl/lsu_top.sv
tb/lsu_asserts.sv
tb/lsu_tb.sv
